/* build.f */
+incdir+hdl
hdl/axis_pkg.sv
hdl/reg_pkg.sv
hdl/app_regs.sv
hdl/pkt_fsm.sv
hdl/app_counters.sv
hdl/egress_stage.sv
hdl/p4_app_top.sv
bench/p4_app_assert.sv
bench/p4_app_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= p4_app_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, fail unless the pass message is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/p4_app_tb.sv */
`timescale 1ns/10ps
`include "p4_app_cfg.svh"

module p4_app_tb
    import axis_pkg::*;
    import reg_pkg::*;
();

    localparam int          DW           = `P4_APP_DATA_WID;
    localparam int          BEAT_W       = DW + 5;
    localparam logic [31:0] SEED         = 32'h5a6f;
    localparam logic [31:0] LFSR_POLY    = 32'h8020_0003;
    localparam int          NUM_PKTS     = 150;
    localparam int          MAX_LEN      = 4;
    localparam int          STALL_FACTOR = 8;
    localparam int          HOLD_CYC     = 12;
    // Two traffic phases plus room for register traffic
    localparam int          TIMEOUT_CYC  = 2 * NUM_PKTS * MAX_LEN * STALL_FACTOR + 1000;

    logic              axil_if;
    logic              arst_n;
    reg_op_e           reg_op;
    reg_addr_e         reg_addr;
    logic [31:0]       reg_wdata;
    logic [31:0]       reg_rdata;
    logic              reg_rvalid;
    logic              in_tvalid;
    logic              in_tready;
    logic [DW-1:0]     in_tdata;
    logic              in_tlast;
    port_t             in_tid;
    logic              out_tvalid;
    logic              out_tready;
    logic [DW-1:0]     out_tdata;
    logic              out_tlast;
    port_t             out_tid;
    egr_tdest_t        out_tdest;

    logic [31:0]       lfsr_q = SEED;
    logic              stall_en;
    int unsigned       errors;
    int unsigned       beats_checked;
    int unsigned       cycle_cnt;
    string             test_name;

    // Reference model state
    logic [2:0]        route_m [`P4_APP_NUM_PORTS];
    logic [BEAT_W-1:0] exp_q [$];
    logic [BEAT_W-1:0] exp_beat;
    int unsigned       fwd_exp;
    int unsigned       drop_exp;
    logic              m_sop;
    logic              m_drop;
    egr_tdest_t        m_dest;

    p4_app_top p4_app_top_i (
        .axil_if    (axil_if),
        .arst_n     (arst_n),
        .reg_op     (reg_op),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .in_tvalid  (in_tvalid),
        .in_tready  (in_tready),
        .in_tdata   (in_tdata),
        .in_tlast   (in_tlast),
        .in_tid     (in_tid),
        .out_tvalid (out_tvalid),
        .out_tready (out_tready),
        .out_tdata  (out_tdata),
        .out_tlast  (out_tlast),
        .out_tid    (out_tid),
        .out_tdest  (out_tdest)
    );

    always #5 axil_if = ~axil_if;

    // Galois LFSR, one step per bit taken
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_POLY) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    task automatic report_mismatch(input string what, input logic [BEAT_W-1:0] exp,
                                   input logic [BEAT_W-1:0] act);
        errors++;
        $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error in %s: %s", test_name, msg);
    endtask

    // Inputs change 1 ns after the edge; egress stalls are drawn here
    task automatic step_cycle();
        @(posedge axil_if);
        #1;
        if (stall_en) begin
            out_tready = (take_bits(2) != 0);
        end
    endtask

    task automatic reg_write(input reg_addr_e addr, input logic [31:0] data);
        reg_op    = REG_WR;
        reg_addr  = addr;
        reg_wdata = data;
        step_cycle();
        reg_op = REG_NOP;
        if (addr >= ADDR_ROUTE0 && addr <= ADDR_ROUTE3) begin
            route_m[int'(addr) - 1] = data[2:0];
        end
        if (addr == ADDR_FWD_CNT) begin
            fwd_exp = 0;
        end
        if (addr == ADDR_DROP_CNT) begin
            drop_exp = 0;
        end
    endtask

    task automatic reg_read(input reg_addr_e addr, output logic [31:0] data);
        reg_op   = REG_RD;
        reg_addr = addr;
        step_cycle();
        reg_op = REG_NOP;
        if (reg_rvalid !== 1'b1) begin
            report_error("reg_rvalid did not pulse one cycle after the read");
        end
        data = reg_rdata;
    endtask

    task automatic send_packet(input port_t tid, input int len);
        logic took;
        for (int b = 0; b < len; b++) begin
            in_tvalid = 1'b1;
            in_tdata  = take_bits(DW);
            in_tlast  = (b == len - 1);
            in_tid    = tid;
            // in_tready is settled by the falling edge
            do begin
                @(negedge axil_if);
                took = in_tready;
                step_cycle();
            end while (!took);
        end
        in_tvalid = 1'b0;
    endtask

    task automatic run_traffic();
        stall_en = 1'b1;
        for (int p = 0; p < NUM_PKTS; p++) begin
            send_packet(port_t'(take_bits(2)), int'(take_bits(2)) + 1);
        end
        while (exp_q.size() != 0) begin
            step_cycle();
        end
        stall_en   = 1'b0;
        out_tready = 1'b1;
    endtask

    // ======================================================================
    // Reference model and egress checker
    // ======================================================================
    always @(posedge axil_if) begin
        if (arst_n) begin
            if (out_tvalid && out_tready) begin
                if (exp_q.size() == 0) begin
                    report_error("output beat appeared with no forwarded beat pending");
                end else begin
                    exp_beat = exp_q.pop_front();
                    beats_checked++;
                    if ({out_tdata, out_tlast, out_tid, out_tdest} !== exp_beat) begin
                        report_mismatch("egress beat", exp_beat,
                                        {out_tdata, out_tlast, out_tid, out_tdest});
                    end
                end
            end
            if (in_tvalid && in_tready) begin
                // Route decision is taken at SOP and kept to tlast
                if (m_sop) begin
                    m_drop = route_m[in_tid][2];
                    m_dest = route_m[in_tid][1:0];
                end
                if (!m_drop) begin
                    exp_q.push_back({in_tdata, in_tlast, in_tid, m_dest});
                end
                m_sop = in_tlast;
                if (in_tlast && m_drop) begin
                    drop_exp++;
                end else if (in_tlast) begin
                    fwd_exp++;
                end
            end
        end
    end

    always @(posedge axil_if) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        logic [31:0] rd;
        logic [31:0] wval;
        logic        took;
        axil_if       = 1'b0;
        arst_n        = 1'b0;
        reg_op        = REG_NOP;
        reg_addr      = ADDR_CTRL;
        reg_wdata     = '0;
        in_tvalid     = 1'b0;
        in_tdata      = '0;
        in_tlast      = 1'b0;
        in_tid        = '0;
        out_tready    = 1'b1;
        stall_en      = 1'b0;
        errors        = 0;
        beats_checked = 0;
        cycle_cnt     = 0;
        fwd_exp       = 0;
        drop_exp      = 0;
        m_sop         = 1'b1;
        m_drop        = 1'b0;
        m_dest        = '0;
        for (int p = 0; p < `P4_APP_NUM_PORTS; p++) begin
            route_m[p] = 3'b000;
        end
        repeat (16) @(posedge axil_if);
        #1;
        arst_n = 1'b1;

        test_name = "reset";
        if (in_tready !== 1'b0) begin
            report_mismatch("in_tready", 0, in_tready);
        end
        if (out_tvalid !== 1'b0) begin
            report_mismatch("out_tvalid", 0, out_tvalid);
        end
        reg_read(ADDR_ID, rd);
        if (rd !== 32'h4150_0001) begin
            report_mismatch("id", 32'h4150_0001, rd);
        end
        reg_read(ADDR_FWD_CNT, rd);
        if (rd !== 32'd0) begin
            report_mismatch("fwd count", 0, rd);
        end

        test_name = "reg_rw";
        for (int a = 1; a <= 4; a++) begin
            wval = take_bits(32);
            reg_write(reg_addr_e'(a), wval);
            reg_read(reg_addr_e'(a), rd);
            if (rd !== {29'b0, wval[2:0]}) begin
                report_mismatch("route entry", {29'b0, wval[2:0]}, rd);
            end
        end
        reg_write(ADDR_CTRL, 32'h0000_0001);
        reg_read(ADDR_CTRL, rd);
        if (rd !== 32'd1) begin
            report_mismatch("ctrl", 1, rd);
        end

        test_name = "routing";
        for (int p = 0; p < `P4_APP_NUM_PORTS; p++) begin
            reg_write(reg_addr_e'(p + 1), {30'b0, 2'(take_bits(2))});
        end
        run_traffic();

        // Odd ports drop, even ports forward
        test_name = "drop";
        for (int p = 0; p < `P4_APP_NUM_PORTS; p++) begin
            reg_write(reg_addr_e'(p + 1), {29'b0, p[0], 2'(take_bits(2))});
        end
        run_traffic();

        test_name = "counters";
        reg_read(ADDR_FWD_CNT, rd);
        if (rd !== fwd_exp) begin
            report_mismatch("fwd count", fwd_exp, rd);
        end
        reg_read(ADDR_DROP_CNT, rd);
        if (rd !== drop_exp) begin
            report_mismatch("drop count", drop_exp, rd);
        end
        reg_write(ADDR_FWD_CNT, 32'hffff_ffff);
        reg_read(ADDR_FWD_CNT, rd);
        if (rd !== 32'd0) begin
            report_mismatch("fwd count after clear", 0, rd);
        end
        reg_write(ADDR_DROP_CNT, 32'hffff_ffff);
        reg_read(ADDR_DROP_CNT, rd);
        if (rd !== 32'd0) begin
            report_mismatch("drop count after clear", 0, rd);
        end

        test_name = "disable";
        reg_write(ADDR_CTRL, 32'd0);
        in_tvalid = 1'b1;
        in_tdata  = take_bits(DW);
        in_tlast  = 1'b1;
        in_tid    = port_t'(2);
        repeat (HOLD_CYC) begin
            @(negedge axil_if);
            if (in_tready !== 1'b0) begin
                report_error("in_tready went high while the block was disabled");
            end
            step_cycle();
        end
        if (exp_q.size() != 0 || fwd_exp != 0) begin
            report_error("a beat was accepted while the block was disabled");
        end
        reg_write(ADDR_CTRL, 32'd1);
        do begin
            @(negedge axil_if);
            took = in_tready;
            step_cycle();
        end while (!took);
        in_tvalid = 1'b0;
        while (exp_q.size() != 0) begin
            step_cycle();
        end
        reg_read(ADDR_FWD_CNT, rd);
        if (rd !== 32'd1) begin
            report_mismatch("held packet count", 1, rd);
        end

        errors += p4_app_top_i.p4_app_assert_i.fail_cnt;
        $display("Summary: %0d errors, %0d egress beats checked", errors, beats_checked);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : p4_app_tb

/* bench/p4_app_assert.sv */
`timescale 1ns/10ps
`include "p4_app_cfg.svh"

module p4_app_assert
    import axis_pkg::*;
    import reg_pkg::*;
(
    input logic                        axil_if,
    input logic                        arst_n,
    input reg_op_e                     reg_op,
    input reg_addr_e                   reg_addr,
    input logic [31:0]                 reg_wdata,
    input logic                        reg_rvalid,
    input logic                        in_tready,
    input logic                        out_tvalid,
    input logic                        out_tready,
    input logic [`P4_APP_DATA_WID-1:0] out_tdata,
    input logic                        out_tlast,
    input port_t                       out_tid,
    input egr_tdest_t                  out_tdest
);

    // Failures seen so far, read by the testbench at the end
    int unsigned fail_cnt = 0;

    // Enable bit as last written over the register port
    logic ctrl_en;

    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_en <= 1'b0;
        end else if (reg_op == REG_WR && reg_addr == ADDR_CTRL) begin
            ctrl_en <= reg_wdata[0];
        end
    end

    // Stalled beat stays valid and unchanged
    out_hold: assert property (@(posedge axil_if) disable iff (!arst_n)
        out_tvalid && !out_tready |=> out_tvalid
            && $stable({out_tdata, out_tlast, out_tid, out_tdest}))
        else begin
            fail_cnt++;
            $error("egress beat dropped or changed while stalled");
        end

    ready_gate: assert property (@(posedge axil_if) disable iff (!arst_n)
        !ctrl_en |-> !in_tready)
        else begin
            fail_cnt++;
            $error("in_tready high while block disabled");
        end

    rvalid_only_after_rd: assert property (@(posedge axil_if) disable iff (!arst_n)
        reg_rvalid |-> $past(reg_op) == REG_RD)
        else begin
            fail_cnt++;
            $error("reg_rvalid without a read one cycle earlier");
        end

    // Egress stays quiet while reset is held
    quiet_in_reset: assert property (@(posedge axil_if) !arst_n |-> !out_tvalid)
        else begin
            fail_cnt++;
            $error("out_tvalid high during reset");
        end

endmodule : p4_app_assert

bind p4_app_top p4_app_assert p4_app_assert_i (
    .axil_if    (axil_if),
    .arst_n     (arst_n),
    .reg_op     (reg_op),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_rvalid (reg_rvalid),
    .in_tready  (in_tready),
    .out_tvalid (out_tvalid),
    .out_tready (out_tready),
    .out_tdata  (out_tdata),
    .out_tlast  (out_tlast),
    .out_tid    (out_tid),
    .out_tdest  (out_tdest)
);

/* hdl/p4_app_top.sv */
`timescale 1ns/10ps
`include "p4_app_cfg.svh"

module p4_app_top
    import axis_pkg::*;
    import reg_pkg::*;
(
    input  logic                        axil_if,
    input  logic                        arst_n,

    // Register port
    input  reg_op_e                     reg_op,
    input  reg_addr_e                   reg_addr,
    input  logic [31:0]                 reg_wdata,
    output logic [31:0]                 reg_rdata,
    output logic                        reg_rvalid,

    // Ingress stream
    input  logic                        in_tvalid,
    output logic                        in_tready,
    input  logic [`P4_APP_DATA_WID-1:0] in_tdata,
    input  logic                        in_tlast,
    input  port_t                       in_tid,

    // Egress stream
    output logic                        out_tvalid,
    input  logic                        out_tready,
    output logic [`P4_APP_DATA_WID-1:0] out_tdata,
    output logic                        out_tlast,
    output port_t                       out_tid,
    output egr_tdest_t                  out_tdest
);

    logic                                           enable;
    logic [`P4_APP_NUM_PORTS*`P4_APP_ROUTE_WID-1:0] route_table;
    logic                                           fwd_clear;
    logic                                           drop_clear;
    logic                                           fwd_done;
    logic                                           drop_done;
    logic [31:0]                                    fwd_count;
    logic [31:0]                                    drop_count;

    // Steered beat into the egress register
    logic                        stage_valid;
    logic                        stage_ready;
    logic [`P4_APP_DATA_WID-1:0] stage_data;
    logic                        stage_last;
    port_t                       stage_tid;
    egr_tdest_t                  stage_tdest;

    // ===================================================================
    // Management side
    // ===================================================================
    app_regs app_regs_i (
        .axil_if     (axil_if),
        .arst_n      (arst_n),
        .reg_op      (reg_op),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .fwd_count   (fwd_count),
        .drop_count  (drop_count),
        .reg_rdata   (reg_rdata),
        .reg_rvalid  (reg_rvalid),
        .enable      (enable),
        .route_table (route_table),
        .fwd_clear   (fwd_clear),
        .drop_clear  (drop_clear)
    );

    app_counters app_counters_i (
        .axil_if    (axil_if),
        .arst_n     (arst_n),
        .fwd_done   (fwd_done),
        .drop_done  (drop_done),
        .fwd_clear  (fwd_clear),
        .drop_clear (drop_clear),
        .fwd_count  (fwd_count),
        .drop_count (drop_count)
    );

    // ===================================================================
    // Datapath
    // ===================================================================
    pkt_fsm pkt_fsm_i (
        .axil_if     (axil_if),
        .arst_n      (arst_n),
        .enable      (enable),
        .route_table (route_table),
        .in_tvalid   (in_tvalid),
        .in_tdata    (in_tdata),
        .in_tlast    (in_tlast),
        .in_tid      (in_tid),
        .stage_ready (stage_ready),
        .in_tready   (in_tready),
        .stage_valid (stage_valid),
        .stage_data  (stage_data),
        .stage_last  (stage_last),
        .stage_tid   (stage_tid),
        .stage_tdest (stage_tdest),
        .fwd_done    (fwd_done),
        .drop_done   (drop_done)
    );

    egress_stage egress_stage_i (
        .axil_if     (axil_if),
        .arst_n      (arst_n),
        .stage_valid (stage_valid),
        .stage_data  (stage_data),
        .stage_last  (stage_last),
        .stage_tid   (stage_tid),
        .stage_tdest (stage_tdest),
        .out_tready  (out_tready),
        .stage_ready (stage_ready),
        .out_tvalid  (out_tvalid),
        .out_tdata   (out_tdata),
        .out_tlast   (out_tlast),
        .out_tid     (out_tid),
        .out_tdest   (out_tdest)
    );

endmodule : p4_app_top

/* hdl/egress_stage.sv */
`timescale 1ns/10ps
`include "p4_app_cfg.svh"

module egress_stage
    import axis_pkg::*;
(
    input  logic                        axil_if,
    input  logic                        arst_n,
    input  logic                        stage_valid,
    input  logic [`P4_APP_DATA_WID-1:0] stage_data,
    input  logic                        stage_last,
    input  port_t                       stage_tid,
    input  egr_tdest_t                  stage_tdest,
    input  logic                        out_tready,
    output logic                        stage_ready,
    output logic                        out_tvalid,
    output logic [`P4_APP_DATA_WID-1:0] out_tdata,
    output logic                        out_tlast,
    output port_t                       out_tid,
    output egr_tdest_t                  out_tdest
);

    logic full_q;
    logic load;

    // Accept when empty, or when the held beat leaves on this edge
    assign stage_ready = !full_q || out_tready;
    assign load        = stage_valid && stage_ready;

    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            full_q <= 1'b0;
        end else if (load) begin
            full_q <= 1'b1;
        end else if (out_tready) begin
            full_q <= 1'b0;
        end
    end

    // Payload only moves on a load, so it holds under back-pressure
    always_ff @(posedge axil_if) begin
        if (load) begin
            out_tdata <= stage_data;
            out_tlast <= stage_last;
            out_tid   <= stage_tid;
            out_tdest <= stage_tdest;
        end
    end

    assign out_tvalid = full_q;

endmodule : egress_stage

/* hdl/app_counters.sv */
`timescale 1ns/10ps

module app_counters (
    input  logic        axil_if,
    input  logic        arst_n,
    input  logic        fwd_done,
    input  logic        drop_done,
    input  logic        fwd_clear,
    input  logic        drop_clear,
    output logic [31:0] fwd_count,
    output logic [31:0] drop_count
);

    localparam int NUM_CNT = 2;
    localparam int CNT_WID = 32;

    // Index 0 counts forwarded packets, index 1 dropped ones
    logic [NUM_CNT-1:0] cnt_inc;
    logic [NUM_CNT-1:0] cnt_clr;
    logic [CNT_WID-1:0] cnt_q [NUM_CNT];

    assign cnt_inc = {drop_done, fwd_done};
    assign cnt_clr = {drop_clear, fwd_clear};

    // ===================================================================
    // Packet counters
    // ===================================================================
    // Clear has priority over a same-cycle increment, counts wrap
    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_CNT; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_CNT; i++) begin
                if (cnt_clr[i]) begin
                    cnt_q[i] <= '0;
                end else if (cnt_inc[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    assign fwd_count  = cnt_q[0];
    assign drop_count = cnt_q[1];

endmodule : app_counters

/* hdl/pkt_fsm.sv */
`timescale 1ns/10ps
`include "p4_app_cfg.svh"

module pkt_fsm
    import axis_pkg::*;
(
    input  logic                          axil_if,
    input  logic                          arst_n,
    input  logic                          enable,
    input  logic [`P4_APP_NUM_PORTS*`P4_APP_ROUTE_WID-1:0] route_table,
    input  logic                          in_tvalid,
    input  logic [`P4_APP_DATA_WID-1:0]   in_tdata,
    input  logic                          in_tlast,
    input  port_t                         in_tid,
    input  logic                          stage_ready,
    output logic                          in_tready,
    output logic                          stage_valid,
    output logic [`P4_APP_DATA_WID-1:0]   stage_data,
    output logic                          stage_last,
    output port_t                         stage_tid,
    output egr_tdest_t                    stage_tdest,
    output logic                          fwd_done,
    output logic                          drop_done
);

    localparam int RW = `P4_APP_ROUTE_WID;

    pkt_state_e    state_q;
    pkt_state_e    state_d;
    egr_tdest_t    dest_q;
    logic [RW-1:0] sop_entry;
    logic          sop_drop;
    egr_tdest_t    sop_dest;
    logic          at_sop;
    logic          drop_now;
    logic          beat_fire;

    // Route lookup for the packet starting now, no added cycle
    assign at_sop    = (state_q == ST_SOP);
    assign sop_entry = route_table[in_tid*RW +: RW];
    assign sop_drop  = sop_entry[RW-1];
    assign sop_dest  = sop_entry[RW-2:0];

    // Dropped beats are swallowed regardless of egress back-pressure
    assign drop_now  = (state_q == ST_DROP) || (at_sop && sop_drop);
    assign in_tready = enable && (drop_now || stage_ready);
    assign beat_fire = in_tvalid && in_tready;

    // Forwarded beats go straight to the egress stage
    assign stage_valid = in_tvalid && enable && !drop_now;
    assign stage_data  = in_tdata;
    assign stage_last  = in_tlast;
    assign stage_tid   = in_tid;
    assign stage_tdest = at_sop ? sop_dest : dest_q;

    assign fwd_done  = beat_fire && in_tlast && !drop_now;
    assign drop_done = beat_fire && in_tlast && drop_now;

    // Single-beat packets never leave ST_SOP
    always_comb begin
        state_d = state_q;
        if (beat_fire) begin
            if (in_tlast) begin
                state_d = ST_SOP;
            end else if (at_sop) begin
                state_d = sop_drop ? ST_DROP : ST_FWD;
            end
        end
    end

    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_SOP;
        end else begin
            state_q <= state_d;
        end
    end

    // Destination is frozen at SOP for the rest of the packet
    always_ff @(posedge axil_if) begin
        if (beat_fire && at_sop) begin
            dest_q <= sop_dest;
        end
    end

endmodule : pkt_fsm

/* hdl/app_regs.sv */
`timescale 1ns/10ps
`include "p4_app_cfg.svh"

module app_regs
    import reg_pkg::*;
(
    input  logic        axil_if,
    input  logic        arst_n,
    input  reg_op_e     reg_op,
    input  reg_addr_e   reg_addr,
    input  logic [31:0] reg_wdata,
    input  logic [31:0] fwd_count,
    input  logic [31:0] drop_count,
    output logic [31:0] reg_rdata,
    output logic        reg_rvalid,
    output logic        enable,
    output logic [`P4_APP_NUM_PORTS*`P4_APP_ROUTE_WID-1:0] route_table,
    output logic        fwd_clear,
    output logic        drop_clear
);

    localparam int PORT_WID = $clog2(`P4_APP_NUM_PORTS);
    localparam int RW       = `P4_APP_ROUTE_WID;

    // Fixed block identifier, read-only
    localparam logic [31:0] ID_VALUE = 32'h4150_0001;

    logic                wr_en;
    logic                rd_en;
    logic                route_hit;
    logic [PORT_WID-1:0] route_off;
    logic [31:0]         rd_mux;

    assign wr_en = (reg_op == REG_WR);
    assign rd_en = (reg_op == REG_RD);

    // Route registers sit at consecutive addresses
    assign route_hit = (reg_addr >= ADDR_ROUTE0) && (reg_addr <= ADDR_ROUTE3);
    assign route_off = PORT_WID'(reg_addr - ADDR_ROUTE0);

    // ===================================================================
    // Write side
    // ===================================================================
    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            enable      <= 1'b0;
            route_table <= '0;
        end else if (wr_en) begin
            if (reg_addr == ADDR_CTRL) begin
                enable <= reg_wdata[0];
            end
            if (route_hit) begin
                route_table[route_off*RW +: RW] <= reg_wdata[RW-1:0];
            end
        end
    end

    // Counter clears fire on the write cycle itself
    assign fwd_clear  = wr_en && (reg_addr == ADDR_FWD_CNT);
    assign drop_clear = wr_en && (reg_addr == ADDR_DROP_CNT);

    // ===================================================================
    // Read side
    // ===================================================================
    always_comb begin
        rd_mux = '0;
        case (reg_addr)
            ADDR_CTRL:     rd_mux = {31'b0, enable};
            ADDR_ROUTE0,
            ADDR_ROUTE1,
            ADDR_ROUTE2,
            ADDR_ROUTE3:   rd_mux = {{(32-RW){1'b0}}, route_table[route_off*RW +: RW]};
            ADDR_FWD_CNT:  rd_mux = fwd_count;
            ADDR_DROP_CNT: rd_mux = drop_count;
            ADDR_ID:       rd_mux = ID_VALUE;
            default:       rd_mux = '0;
        endcase
    end

    // Read data is held until the next read
    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            reg_rvalid <= 1'b0;
            reg_rdata  <= '0;
        end else begin
            reg_rvalid <= rd_en;
            if (rd_en) begin
                reg_rdata <= rd_mux;
            end
        end
    end

endmodule : app_regs

/* hdl/reg_pkg.sv */
`include "p4_app_cfg.svh"

package reg_pkg;

    // Register port opcodes, held for a single cycle
    typedef enum logic [1:0] {
        REG_NOP = 2'd0,
        REG_WR  = 2'd1,
        REG_RD  = 2'd2
    } reg_op_e;

    // Register map
    typedef enum logic [`P4_APP_ADDR_WID-1:0] {
        ADDR_CTRL     = 3'd0,
        ADDR_ROUTE0   = 3'd1,
        ADDR_ROUTE1   = 3'd2,
        ADDR_ROUTE2   = 3'd3,
        ADDR_ROUTE3   = 3'd4,
        ADDR_FWD_CNT  = 3'd5,
        ADDR_DROP_CNT = 3'd6,
        ADDR_ID       = 3'd7
    } reg_addr_e;

endpackage : reg_pkg

/* hdl/axis_pkg.sv */
`include "p4_app_cfg.svh"

package axis_pkg;

    // Ingress port id, sized from the port count
    typedef logic [$clog2(`P4_APP_NUM_PORTS)-1:0] port_t;

    // Egress destination attached to forwarded beats
    typedef logic [`P4_APP_ROUTE_WID-2:0] egr_tdest_t;

    // Per-packet steering state
    typedef enum logic [1:0] {
        ST_SOP  = 2'd0,
        ST_FWD  = 2'd1,
        ST_DROP = 2'd2
    } pkt_state_e;

endpackage : axis_pkg

/* hdl/p4_app_cfg.svh */
`ifndef P4_APP_CFG_SVH
`define P4_APP_CFG_SVH

// Stream beat width in bits
`define P4_APP_DATA_WID 64

// Ingress ports, one route entry per port
`define P4_APP_NUM_PORTS 4

// Register address width
`define P4_APP_ADDR_WID 3

// Route entry: destination in the low bits, drop flag on top
`define P4_APP_ROUTE_WID 3

`endif
